// ==== Bender.yml ====
package:
  name: openmips

sources:
  - files:
      - rtl/mips_pkg.sv
      - rtl/if_stage.sv
      - rtl/id_stage.sv
      - rtl/regfile.sv
      - rtl/id_ex.sv
      - rtl/ex_stage.sv
      - rtl/ex_mem.sv
      - rtl/mem_wb.sv
      - rtl/hilo_reg.sv
      - rtl/openmips.sv
  - target: test
    files:
      - verification/openmips_tb.sv

// ==== rtl/ex_mem.sv ====
// execute/memory register, bubble on stall, madd state loop-back
module ex_mem import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  reg_addr_t waddr_i,
    input  logic      wreg_i,
    input  word_t     result_i,
    input  logic      hi_we_i,
    input  logic      lo_we_i,
    input  word_t     hi_i,
    input  word_t     lo_i,
    input  logic      madd_cnt_i,
    input  dword_t    madd_acc_i,
    output reg_addr_t waddr_o,
    output logic      wreg_o,
    output word_t     result_o,
    output logic      hi_we_o,
    output logic      lo_we_o,
    output word_t     hi_o,
    output word_t     lo_o,
    output logic      madd_cnt_o,
    output dword_t    madd_acc_o
);
    always_ff @(posedge clk) begin
        if (!rst_n_i || stall_i) begin  // reset and stall both load a bubble
            wreg_o   <= 1'b0;
            hi_we_o  <= 1'b0;
            lo_we_o  <= 1'b0;
            waddr_o  <= '0;
            result_o <= '0;
        end else begin
            wreg_o   <= wreg_i;
            hi_we_o  <= hi_we_i;
            lo_we_o  <= lo_we_i;
            waddr_o  <= waddr_i;
            result_o <= result_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            madd_cnt_o <= 1'b0;
        end else begin
            madd_cnt_o <= stall_i ? madd_cnt_i : 1'b0;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        hi_o       <= hi_i;
        lo_o       <= lo_i;
        madd_acc_o <= madd_acc_i;
    end

    a_bubble_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> madd_cnt_o && !(wreg_o || hi_we_o || lo_we_o))
        else $error("write enable set in stall bubble");

    // ex_stage must release the stall once the count returns
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> !stall_i)
        else $error("stall request held for more than one cycle");

endmodule

// ==== rtl/ex_stage.sv ====
// alu, shifter, hi/lo moves and the two cycle madd sequence
module ex_stage import mips_pkg::*; (
    input  alu_op_e   alu_op_i,
    input  word_t     opnd1_i,
    input  word_t     opnd2_i,
    input  shamt_t    shamt_i,
    input  reg_addr_t waddr_i,
    input  logic      wreg_i,
    input  word_t     hi_i,
    input  word_t     lo_i,
    input  logic      madd_cnt_i,
    input  dword_t    madd_acc_i,
    output reg_addr_t waddr_o,
    output logic      wreg_o,
    output word_t     result_o,
    output logic      hi_we_o,
    output logic      lo_we_o,
    output word_t     hi_o,
    output word_t     lo_o,
    output logic      stall_req_o,
    output logic      madd_cnt_o,
    output dword_t    madd_acc_o
);
    typedef enum logic {MADD_MUL, MADD_ACC} madd_state_e;

    madd_state_e madd_state;
    dword_t      product;

    assign waddr_o    = waddr_i;
    assign wreg_o     = wreg_i;
    assign madd_state = madd_state_e'(madd_cnt_i);  // counter comes back from ex_mem

    // low 64 bits of the sign extended product give the signed result
    assign product    = {{32{opnd1_i[31]}}, opnd1_i} * {{32{opnd2_i[31]}}, opnd2_i};
    assign madd_acc_o = product;

    always_comb begin
        result_o    = '0;
        hi_we_o     = 1'b0;
        lo_we_o     = 1'b0;
        hi_o        = hi_i;
        lo_o        = lo_i;
        stall_req_o = 1'b0;
        madd_cnt_o  = 1'b0;
        case (alu_op_i)
            ALU_AND:  result_o = opnd1_i & opnd2_i;
            ALU_OR:   result_o = opnd1_i | opnd2_i;
            ALU_XOR:  result_o = opnd1_i ^ opnd2_i;
            ALU_NOR:  result_o = ~(opnd1_i | opnd2_i);
            ALU_LUI:  result_o = {opnd2_i[15:0], 16'h0000};
            ALU_ADDU: result_o = opnd1_i + opnd2_i;
            ALU_SUBU: result_o = opnd1_i - opnd2_i;
            ALU_SLL:  result_o = opnd2_i << shamt_i;
            ALU_SRL:  result_o = opnd2_i >> shamt_i;
            ALU_MFHI: result_o = hi_i;  // already forwarded by hilo_reg
            ALU_MFLO: result_o = lo_i;
            ALU_MTHI: begin
                hi_we_o = 1'b1;
                hi_o    = opnd1_i;
            end
            ALU_MTLO: begin
                lo_we_o = 1'b1;
                lo_o    = opnd1_i;
            end
            ALU_MADD: begin
                if (madd_state == MADD_MUL) begin
                    stall_req_o = 1'b1;  // park product in ex_mem
                    madd_cnt_o  = 1'b1;
                end else begin
                    {hi_o, lo_o} = {hi_i, lo_i} + madd_acc_i;
                    hi_we_o      = 1'b1;
                    lo_we_o      = 1'b1;
                end
            end
            default: result_o = '0;
        endcase
    end

endmodule

// ==== rtl/hilo_reg.sv ====
// hi and lo registers with forwarding from memory slot and write-back
module hilo_reg import mips_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  wb_hi_we_i,
    input  logic  wb_lo_we_i,
    input  word_t wb_hi_i,
    input  word_t wb_lo_i,
    input  logic  mem_hi_we_i,
    input  logic  mem_lo_we_i,
    input  word_t mem_hi_i,
    input  word_t mem_lo_i,
    output word_t hi_o,
    output word_t lo_o
);
    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (wb_hi_we_i) hi_q <= wb_hi_i;
            if (wb_lo_we_i) lo_q <= wb_lo_i;
        end
    end

    // memory slot is younger than write-back
    assign hi_o = mem_hi_we_i ? mem_hi_i : (wb_hi_we_i ? wb_hi_i : hi_q);
    assign lo_o = mem_lo_we_i ? mem_lo_i : (wb_lo_we_i ? wb_lo_i : lo_q);

endmodule

// ==== rtl/id_ex.sv ====
// decode/execute pipeline register
module id_ex import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      stall_i,
    input  alu_op_e   alu_op_i,
    input  word_t     opnd1_i,
    input  word_t     opnd2_i,
    input  shamt_t    shamt_i,
    input  reg_addr_t waddr_i,
    input  logic      wreg_i,
    output alu_op_e   alu_op_o,
    output word_t     opnd1_o,
    output word_t     opnd2_o,
    output shamt_t    shamt_o,
    output reg_addr_t waddr_o,
    output logic      wreg_o
);
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alu_op_o <= ALU_NOP;
            opnd1_o  <= '0;
            opnd2_o  <= '0;
            shamt_o  <= '0;
            waddr_o  <= '0;
            wreg_o   <= 1'b0;
        end else if (!stall_i) begin  // madd keeps its slot for the second cycle
            alu_op_o <= alu_op_i;
            opnd1_o  <= opnd1_i;
            opnd2_o  <= opnd2_i;
            shamt_o  <= shamt_i;
            waddr_o  <= waddr_i;
            wreg_o   <= wreg_i;
        end
    end

endmodule

// ==== rtl/id_stage.sv ====
// instruction decoder, register read requests and operand selection
module id_stage import mips_pkg::*; (
    input  word_t     inst_i,
    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,
    output logic      reg1_re_o,
    output reg_addr_t reg1_addr_o,
    output logic      reg2_re_o,
    output reg_addr_t reg2_addr_o,
    output alu_op_e   alu_op_o,
    output word_t     opnd1_o,
    output word_t     opnd2_o,
    output shamt_t    shamt_o,
    output reg_addr_t waddr_o,
    output logic      wreg_o
);
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       i_type;
    word_t      imm;

    assign opcode      = inst_i[31:26];
    assign funct       = inst_i[5:0];
    assign reg1_addr_o = inst_i[25:21];  // rs
    assign reg2_addr_o = inst_i[20:16];  // rt
    assign i_type      = opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDIU};
    assign waddr_o     = i_type ? inst_i[20:16] : inst_i[15:11];
    assign shamt_o     = inst_i[10:6];
    assign opnd1_o     = reg1_data_i;  // zero when port not enabled
    assign opnd2_o     = i_type ? imm : reg2_data_i;

    always_comb begin
        alu_op_o = ALU_NOP;  // anything unknown becomes a bubble
        imm      = {16'h0000, inst_i[15:0]};
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_NOR:  alu_op_o = ALU_NOR;
                    FN_ADDU: alu_op_o = ALU_ADDU;
                    FN_SUBU: alu_op_o = ALU_SUBU;
                    FN_SLL:  alu_op_o = ALU_SLL;
                    FN_SRL:  alu_op_o = ALU_SRL;
                    FN_MFHI: alu_op_o = ALU_MFHI;
                    FN_MFLO: alu_op_o = ALU_MFLO;
                    FN_MTHI: alu_op_o = ALU_MTHI;
                    FN_MTLO: alu_op_o = ALU_MTLO;
                    default: alu_op_o = ALU_NOP;
                endcase
            end
            OP_SPECIAL2: begin
                if (funct == FN_MADD) begin
                    alu_op_o = ALU_MADD;
                end
            end
            OP_ANDI: alu_op_o = ALU_AND;
            OP_ORI:  alu_op_o = ALU_OR;
            OP_XORI: alu_op_o = ALU_XOR;
            OP_LUI:  alu_op_o = ALU_LUI;
            OP_ADDIU: begin
                alu_op_o = ALU_ADDU;
                imm      = {{16{inst_i[15]}}, inst_i[15:0]};  // sign extend
            end
            default: alu_op_o = ALU_NOP;
        endcase
    end

    // port usage follows from the operation
    assign reg1_re_o = alu_op_o inside {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_ADDU,
                                        ALU_SUBU, ALU_MTHI, ALU_MTLO, ALU_MADD};
    assign reg2_re_o = !i_type && (alu_op_o inside {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
                                   ALU_ADDU, ALU_SUBU, ALU_SLL, ALU_SRL, ALU_MADD});
    assign wreg_o    = !(alu_op_o inside {ALU_NOP, ALU_MTHI, ALU_MTLO, ALU_MADD});

endmodule

// ==== rtl/if_stage.sv ====
// program counter, rom enable and fetch/decode register
module if_stage import mips_pkg::*; #(
    parameter inst_addr_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       stall_i,
    input  word_t      rom_data_i,
    output logic       rom_ce_o,
    output inst_addr_t rom_addr_o,
    output word_t      inst_o
);
    inst_addr_t pc;

    assign rom_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rom_ce_o <= 1'b0;
            pc       <= RESET_PC;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o && !stall_i) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // fetch/decode register, held while execute stalls
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_o <= NOP_INST;
        end else if (!stall_i) begin
            inst_o <= rom_ce_o ? rom_data_i : NOP_INST;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc[1:0] == 2'b00)
        else $error("program counter not word aligned: %h", pc);

endmodule

// ==== rtl/mem_wb.sv ====
// memory/write-back register feeding regfile and hi/lo
module mem_wb import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t waddr_i,
    input  logic      wreg_i,
    input  word_t     result_i,
    input  logic      hi_we_i,
    input  logic      lo_we_i,
    input  word_t     hi_i,
    input  word_t     lo_i,
    output reg_addr_t waddr_o,
    output logic      wreg_o,
    output word_t     result_o,
    output logic      hi_we_o,
    output logic      lo_we_o,
    output word_t     hi_o,
    output word_t     lo_o
);
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wreg_o  <= 1'b0;
            hi_we_o <= 1'b0;
            lo_we_o <= 1'b0;
        end else begin
            wreg_o  <= wreg_i;
            hi_we_o <= hi_we_i;
            lo_we_o <= lo_we_i;
        end
    end

    always_ff @(posedge clk) begin
        waddr_o  <= waddr_i;
        result_o <= result_i;
        hi_o     <= hi_i;
        lo_o     <= lo_i;
    end

endmodule

// ==== rtl/mips_pkg.sv ====
// word, address and field types, opcode and function codes, alu operation enum
package mips_pkg;

    typedef logic [31:0] word_t;       // general register or data word
    typedef logic [63:0] dword_t;      // hi:lo pair
    typedef logic [31:0] inst_addr_t;  // instruction byte address
    typedef logic [4:0]  reg_addr_t;   // register number
    typedef logic [4:0]  shamt_t;      // shift amount field

    // opcode field, bits 31:26
    localparam logic [5:0] OP_SPECIAL  = 6'b000000;
    localparam logic [5:0] OP_SPECIAL2 = 6'b011100;
    localparam logic [5:0] OP_ANDI     = 6'b001100;
    localparam logic [5:0] OP_ORI      = 6'b001101;
    localparam logic [5:0] OP_XORI     = 6'b001110;
    localparam logic [5:0] OP_LUI      = 6'b001111;
    localparam logic [5:0] OP_ADDIU    = 6'b001001;

    // function field under SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_MFHI = 6'b010000;
    localparam logic [5:0] FN_MTHI = 6'b010001;
    localparam logic [5:0] FN_MFLO = 6'b010010;
    localparam logic [5:0] FN_MTLO = 6'b010011;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;

    // function field under SPECIAL2
    localparam logic [5:0] FN_MADD = 6'b000000;

    localparam word_t NOP_INST = 32'h0000_0000;  // sll $0, $0, 0

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI,
        ALU_ADDU, ALU_SUBU, ALU_SLL, ALU_SRL,
        ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
        ALU_MADD
    } alu_op_e;

endpackage

// ==== rtl/openmips.sv ====
// core top level, rom pins and write-back observation
module openmips import mips_pkg::*; #(
    parameter inst_addr_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  word_t      rom_data_i,
    output logic       rom_ce_o,
    output inst_addr_t rom_addr_o,
    output logic       wb_we_o,
    output reg_addr_t  wb_waddr_o,
    output word_t      wb_wdata_o
);
    logic      stall_req;
    word_t     id_inst;
    logic      re1, re2;
    reg_addr_t raddr1, raddr2;
    word_t     rdata1, rdata2;
    alu_op_e   id_op, ex_op;
    word_t     id_opnd1, id_opnd2, ex_opnd1, ex_opnd2;
    shamt_t    id_shamt, ex_shamt;
    reg_addr_t id_waddr, ex_waddr_in, ex_waddr, mem_waddr;
    logic      id_wreg, ex_wreg_in, ex_wreg, mem_wreg;
    word_t     ex_result, mem_result;
    logic      ex_hi_we, ex_lo_we, mem_hi_we, mem_lo_we, wb_hi_we, wb_lo_we;
    word_t     ex_hi, ex_lo, mem_hi, mem_lo, wb_hi, wb_lo, hi_fwd, lo_fwd;
    logic      madd_cnt_ex, madd_cnt_mem;
    dword_t    madd_acc_ex, madd_acc_mem;

    if_stage #(.RESET_PC(RESET_PC)) if_stage_0 (
        .clk, .rst_n_i, .stall_i(stall_req), .rom_data_i,
        .rom_ce_o, .rom_addr_o, .inst_o(id_inst));

    id_stage id_stage_0 (
        .inst_i(id_inst), .reg1_data_i(rdata1), .reg2_data_i(rdata2),
        .reg1_re_o(re1), .reg1_addr_o(raddr1), .reg2_re_o(re2), .reg2_addr_o(raddr2),
        .alu_op_o(id_op), .opnd1_o(id_opnd1), .opnd2_o(id_opnd2), .shamt_o(id_shamt),
        .waddr_o(id_waddr), .wreg_o(id_wreg));

    regfile regfile_0 (
        .clk, .rst_n_i, .we_i(wb_we_o), .waddr_i(wb_waddr_o), .wdata_i(wb_wdata_o),
        .ex_we_i(ex_wreg), .ex_waddr_i(ex_waddr), .ex_wdata_i(ex_result),
        .mem_we_i(mem_wreg), .mem_waddr_i(mem_waddr), .mem_wdata_i(mem_result),
        .re1_i(re1), .raddr1_i(raddr1), .rdata1_o(rdata1),
        .re2_i(re2), .raddr2_i(raddr2), .rdata2_o(rdata2));

    id_ex id_ex_0 (
        .clk, .rst_n_i, .stall_i(stall_req),
        .alu_op_i(id_op), .opnd1_i(id_opnd1), .opnd2_i(id_opnd2), .shamt_i(id_shamt),
        .waddr_i(id_waddr), .wreg_i(id_wreg),
        .alu_op_o(ex_op), .opnd1_o(ex_opnd1), .opnd2_o(ex_opnd2), .shamt_o(ex_shamt),
        .waddr_o(ex_waddr_in), .wreg_o(ex_wreg_in));

    ex_stage ex_stage_0 (
        .alu_op_i(ex_op), .opnd1_i(ex_opnd1), .opnd2_i(ex_opnd2), .shamt_i(ex_shamt),
        .waddr_i(ex_waddr_in), .wreg_i(ex_wreg_in), .hi_i(hi_fwd), .lo_i(lo_fwd),
        .madd_cnt_i(madd_cnt_mem), .madd_acc_i(madd_acc_mem),
        .waddr_o(ex_waddr), .wreg_o(ex_wreg), .result_o(ex_result),
        .hi_we_o(ex_hi_we), .lo_we_o(ex_lo_we), .hi_o(ex_hi), .lo_o(ex_lo),
        .stall_req_o(stall_req), .madd_cnt_o(madd_cnt_ex), .madd_acc_o(madd_acc_ex));

    ex_mem ex_mem_0 (
        .clk, .rst_n_i, .stall_i(stall_req),
        .waddr_i(ex_waddr), .wreg_i(ex_wreg), .result_i(ex_result),
        .hi_we_i(ex_hi_we), .lo_we_i(ex_lo_we), .hi_i(ex_hi), .lo_i(ex_lo),
        .madd_cnt_i(madd_cnt_ex), .madd_acc_i(madd_acc_ex),
        .waddr_o(mem_waddr), .wreg_o(mem_wreg), .result_o(mem_result),
        .hi_we_o(mem_hi_we), .lo_we_o(mem_lo_we), .hi_o(mem_hi), .lo_o(mem_lo),
        .madd_cnt_o(madd_cnt_mem), .madd_acc_o(madd_acc_mem));

    mem_wb mem_wb_0 (
        .clk, .rst_n_i,
        .waddr_i(mem_waddr), .wreg_i(mem_wreg), .result_i(mem_result),
        .hi_we_i(mem_hi_we), .lo_we_i(mem_lo_we), .hi_i(mem_hi), .lo_i(mem_lo),
        .waddr_o(wb_waddr_o), .wreg_o(wb_we_o), .result_o(wb_wdata_o),
        .hi_we_o(wb_hi_we), .lo_we_o(wb_lo_we), .hi_o(wb_hi), .lo_o(wb_lo));

    hilo_reg hilo_reg_0 (
        .clk, .rst_n_i,
        .wb_hi_we_i(wb_hi_we), .wb_lo_we_i(wb_lo_we), .wb_hi_i(wb_hi), .wb_lo_i(wb_lo),
        .mem_hi_we_i(mem_hi_we), .mem_lo_we_i(mem_lo_we), .mem_hi_i(mem_hi), .mem_lo_i(mem_lo),
        .hi_o(hi_fwd), .lo_o(lo_fwd));

endmodule

// ==== rtl/regfile.sv ====
// 32 x 32 register file, one write port, two forwarding read ports
module regfile import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  logic      ex_we_i,
    input  reg_addr_t ex_waddr_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_we_i,
    input  reg_addr_t mem_waddr_i,
    input  word_t     mem_wdata_i,
    input  logic      re1_i,
    input  reg_addr_t raddr1_i,
    output word_t     rdata1_o,
    input  logic      re2_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata2_o
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            regs <= '{default: '0};
        end else if (we_i && waddr_i != '0) begin  // $0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // youngest producer wins
    function automatic word_t read_fwd(input logic re, input reg_addr_t raddr);
        if (!re || raddr == '0)
            return '0;
        if (ex_we_i && ex_waddr_i == raddr)
            return ex_wdata_i;
        if (mem_we_i && mem_waddr_i == raddr)
            return mem_wdata_i;
        if (we_i && waddr_i == raddr)
            return wdata_i;
        return regs[raddr];
    endfunction

    always_comb begin
        rdata1_o = read_fwd(re1_i, raddr1_i);
        rdata2_o = read_fwd(re2_i, raddr2_i);
    end

endmodule

// ==== sim.f ====
rtl/mips_pkg.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/regfile.sv
rtl/id_ex.sv
rtl/ex_stage.sv
rtl/ex_mem.sv
rtl/mem_wb.sv
rtl/hilo_reg.sv
rtl/openmips.sv
verification/openmips_tb.sv

// ==== verification/openmips_tb.sv ====
// openmips testbench with clock, reset, rom model, program builder, reference model and checks
module openmips_tb import mips_pkg::*; ();

    localparam inst_addr_t RESET_PC   = 32'h0000_0040;
    localparam int         RAND_COUNT = 40;
    localparam int         MAX_PROG   = 128;

    logic       clk;
    logic       rst_n_i;
    word_t      rom_data_i;
    logic       rom_ce_o;
    inst_addr_t rom_addr_o;
    logic       wb_we_o;
    reg_addr_t  wb_waddr_o;
    word_t      wb_wdata_o;

    word_t      prog [MAX_PROG];
    int         prog_len;
    reg_addr_t  exp_addr_q [$];  // expected write-backs, program order
    word_t      exp_data_q [$];
    word_t      rng_state;
    inst_addr_t rom_index;
    int         cycle_limit;
    int         cycle_count = 0;
    logic       writes_done = 1'b0;

    openmips #(.RESET_PC(RESET_PC)) dut (
        .clk, .rst_n_i, .rom_data_i, .rom_ce_o, .rom_addr_o,
        .wb_we_o, .wb_waddr_o, .wb_wdata_o);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // combinational rom, nop outside the program
    assign rom_index  = (rom_addr_o - RESET_PC) >> 2;
    assign rom_data_i = (rom_ce_o === 1'b1 && rom_index < prog_len) ? prog[rom_index] : NOP_INST;

    function automatic word_t xorshift32(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t enc_r(int fn, int rs, int rt, int rd, int sa);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn[5:0]};
    endfunction

    function automatic word_t enc_i(int op, int rs, int rt, int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t enc_madd(int rs, int rt);
        return {OP_SPECIAL2, rs[4:0], rt[4:0], 10'd0, FN_MADD};
    endfunction

    function automatic void append_inst(word_t w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    // registers 0..7 only, so random ops depend on each other often
    function automatic word_t random_inst();
        word_t r;
        word_t s;
        int    rs, rt, rd, sa, imm;
        r   = next_random();
        s   = next_random();
        rs  = int'(r[2:0]);
        rt  = int'(r[5:3]);
        rd  = int'(r[8:6]);
        sa  = int'(r[13:9]);
        imm = int'(r[29:14]);
        case (s % 18)
            0:       return enc_r(FN_AND, rs, rt, rd, 0);
            1:       return enc_r(FN_OR, rs, rt, rd, 0);
            2:       return enc_r(FN_XOR, rs, rt, rd, 0);
            3:       return enc_r(FN_NOR, rs, rt, rd, 0);
            4:       return enc_r(FN_ADDU, rs, rt, rd, 0);
            5:       return enc_r(FN_SUBU, rs, rt, rd, 0);
            6:       return enc_r(FN_SLL, 0, rt, rd, sa);
            7:       return enc_r(FN_SRL, 0, rt, rd, sa);
            8:       return enc_r(FN_MFHI, 0, 0, rd, 0);
            9:       return enc_r(FN_MFLO, 0, 0, rd, 0);
            10:      return enc_r(FN_MTHI, rs, 0, 0, 0);
            11:      return enc_r(FN_MTLO, rs, 0, 0, 0);
            12:      return enc_madd(rs, rt);
            13:      return enc_i(OP_ANDI, rs, rt, imm);
            14:      return enc_i(OP_ORI, rs, rt, imm);
            15:      return enc_i(OP_XORI, rs, rt, imm);
            16:      return enc_i(OP_LUI, 0, rt, imm);
            default: return enc_i(OP_ADDIU, rs, rt, imm);
        endcase
    endfunction

    function automatic void build_program();
        prog_len = 0;
        append_inst(enc_i(OP_ORI, 0, 1, 'h8001));    // zero extended
        append_inst(enc_i(OP_ADDIU, 0, 2, 'h8001));  // sign extended
        append_inst(enc_i(OP_LUI, 0, 3, 'ha5a5));
        append_inst(enc_i(OP_ANDI, 2, 4, 'hf0f0));
        append_inst(enc_i(OP_XORI, 3, 5, 'hffff));
        // dependent chain, distances one to three
        append_inst(enc_i(OP_ADDIU, 0, 7, 'h0011));
        append_inst(enc_r(FN_ADDU, 7, 7, 8, 0));
        append_inst(enc_r(FN_SUBU, 8, 7, 9, 0));
        append_inst(enc_r(FN_NOR, 7, 8, 10, 0));
        append_inst(enc_r(FN_AND, 9, 10, 11, 0));
        append_inst(enc_r(FN_XOR, 11, 3, 12, 0));
        append_inst(enc_r(FN_SLL, 0, 12, 13, 4));
        append_inst(enc_r(FN_SRL, 0, 13, 14, 7));
        append_inst(enc_i(OP_ADDIU, 7, 0, 5));       // write to $0
        append_inst(enc_r(FN_OR, 0, 7, 15, 0));
        append_inst(enc_r(FN_MTHI, 2, 0, 0, 0));
        append_inst(enc_r(FN_MTLO, 3, 0, 0, 0));
        append_inst(enc_r(FN_MFHI, 0, 0, 16, 0));
        append_inst(enc_r(FN_MFLO, 0, 0, 17, 0));
        // madd and the instructions behind it
        append_inst(enc_i(OP_ADDIU, 0, 18, -3));
        append_inst(enc_i(OP_LUI, 0, 19, 2));
        append_inst(enc_madd(18, 19));
        append_inst(enc_r(FN_MFHI, 0, 0, 20, 0));
        append_inst(enc_r(FN_MFLO, 0, 0, 21, 0));
        append_inst(enc_r(FN_ADDU, 20, 21, 22, 0));
        append_inst(enc_madd(19, 19));
        append_inst(enc_r(FN_MFLO, 0, 0, 23, 0));
        append_inst(enc_r(FN_MFHI, 0, 0, 24, 0));
        for (int n = 0; n < RAND_COUNT; n++) begin
            append_inst(random_inst());
        end
    endfunction

    // sequential interpreter of the whole program
    function automatic void run_reference();
        word_t     gpr [32];
        word_t     hi, lo, ins, a, b, res;
        longint    sa, sb;
        logic      wr;
        reg_addr_t dst;
        for (int i = 0; i < 32; i++) begin
            gpr[i] = '0;
        end
        hi = '0;
        lo = '0;
        for (int n = 0; n < prog_len; n++) begin
            ins = prog[n];
            a   = gpr[ins[25:21]];
            b   = gpr[ins[20:16]];
            dst = (ins[31:26] == OP_SPECIAL) ? ins[15:11] : ins[20:16];
            res = '0;
            wr  = 1'b1;
            case (ins[31:26])
                OP_SPECIAL: begin
                    case (ins[5:0])
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_NOR:  res = ~(a | b);
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_SLL:  res = b << ins[10:6];
                        FN_SRL:  res = b >> ins[10:6];
                        FN_MFHI: res = hi;
                        FN_MFLO: res = lo;
                        FN_MTHI: begin
                            hi = a;
                            wr = 1'b0;
                        end
                        FN_MTLO: begin
                            lo = a;
                            wr = 1'b0;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OP_SPECIAL2: begin
                    sa       = $signed(a);
                    sb       = $signed(b);
                    {hi, lo} = {hi, lo} + (sa * sb);  // signed 64 bit accumulate
                    wr       = 1'b0;
                end
                OP_ANDI:  res = a & {16'h0000, ins[15:0]};
                OP_ORI:   res = a | {16'h0000, ins[15:0]};
                OP_XORI:  res = a ^ {16'h0000, ins[15:0]};
                OP_LUI:   res = {ins[15:0], 16'h0000};
                OP_ADDIU: res = a + {{16{ins[15]}}, ins[15:0]};
                default:  wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                gpr[dst] = res;
                exp_addr_q.push_back(dst);
                exp_data_q.push_back(res);
            end
        end
    endfunction

    task automatic stop_on_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
            stop_on_failure();
        end
    endtask

    // compare each register write-back against the reference
    always @(posedge clk) begin
        if (rst_n_i === 1'b1 && wb_we_o === 1'b1 && wb_waddr_o != '0) begin
            if (exp_addr_q.size() == 0) begin
                $display("unexpected write-back to register %0d at time %0t", wb_waddr_o, $time);
                stop_on_failure();
            end else begin
                check_value("wb_waddr_o", wb_waddr_o, exp_addr_q.pop_front());
                check_value("wb_wdata_o", wb_wdata_o, exp_data_q.pop_front());
                if (exp_addr_q.size() == 0) writes_done <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n_i === 1'b1) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("timeout after %0d cycles, the pipeline stopped writing back",
                         cycle_count);
                stop_on_failure();
            end
        end
    end

    initial begin
        rst_n_i   = 1'b0;
        rng_state = 32'd71;
        build_program();
        run_reference();
        cycle_limit = prog_len * 2 + 20;
        @(posedge clk);
        repeat (4) begin  // outputs settled by the first reset edge
            @(posedge clk);
            check_value("rom_ce_o", rom_ce_o, 1'b0);
            check_value("wb_we_o", wb_we_o, 1'b0);
        end
        rst_n_i <= 1'b1;
        @(posedge clk);
        while (rom_ce_o !== 1'b1) begin
            @(posedge clk);
        end
        check_value("rom_addr_o", rom_addr_o, RESET_PC);  // first fetch
        wait (writes_done === 1'b1);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
